/* verilog/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and address width
`define CORE_XLEN 32

// register file index width, 32 registers
`define CORE_RADDR_W 5

// instruction memory size in 32-bit words
`define CORE_IMEM_DEPTH 256

`endif

/* verilog/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// the only SYSTEM word we accept
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 for BRANCH
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	// funct7 for OP
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	localparam logic [`CORE_RADDR_W-1:0] REG_X0 = '0;

	// one instruction is four bytes
	localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		NPC_SEQ,
		NPC_BEQ,
		NPC_BNE,
		NPC_JUMP
	} npc_kind_e;

endpackage

/* verilog/core_ifu.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_ifu (
	input  logic                                  clk,
	input  logic                                  arst_n_i,
	input  logic                                  run_i,
	input  logic                                  finish_i,
	input  logic                                  halt_i,
	input  logic                                  redirect_i,
	input  logic [`CORE_XLEN-1:0]                 redirect_pc_i,
	input  logic                                  imem_we_i,
	input  logic [$clog2(`CORE_IMEM_DEPTH)-1:0]   imem_addr_i,
	input  logic [`CORE_XLEN-1:0]                 imem_wdata_i,
	output logic                                  valid_o,
	output logic [`CORE_XLEN-1:0]                 inst_o,
	output logic [`CORE_XLEN-1:0]                 pc_o
);
	import core_pkg::*;

	localparam int IMEM_AW = $clog2(`CORE_IMEM_DEPTH);

	logic [`CORE_XLEN-1:0] imem [`CORE_IMEM_DEPTH];
	logic [`CORE_XLEN-1:0] next_pc;
	logic [`CORE_XLEN-1:0] fetch_pc;
	logic                  busy;
	logic                  fetch_go;

	// pc of the following instruction, known once the current one retires
	assign next_pc  = redirect_i ? redirect_pc_i : pc_o + PC_STEP;
	assign fetch_pc = finish_i ? next_pc : pc_o;

	// one instruction in flight; finish frees the slot
	assign fetch_go = (!busy || finish_i) && run_i && !halt_i;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o    <= '0;
			busy    <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= fetch_go;
			if (finish_i)
				pc_o <= next_pc;
			if (fetch_go)
				busy <= 1'b1;
			else if (finish_i)
				busy <= 1'b0;
		end
	end

	// program load port and instruction register
	always_ff @(posedge clk) begin
		if (imem_we_i)
			imem[imem_addr_i] <= imem_wdata_i;
		if (fetch_go)
			inst_o <= imem[fetch_pc[IMEM_AW+1:2]];
	end

endmodule

/* verilog/core_regfile.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_regfile (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic [`CORE_RADDR_W-1:0] raddr1_i,
	input  logic [`CORE_RADDR_W-1:0] raddr2_i,
	input  logic                     we_i,
	input  logic [`CORE_RADDR_W-1:0] waddr_i,
	input  logic [`CORE_XLEN-1:0]    wdata_i,
	output logic [`CORE_XLEN-1:0]    rdata1_o,
	output logic [`CORE_XLEN-1:0]    rdata2_o
);

	logic [`CORE_XLEN-1:0] regs [2**`CORE_RADDR_W];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 2**`CORE_RADDR_W; i++)
				regs[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			// x0 never takes a write, so it reads zero
			regs[waddr_i] <= wdata_i;
		end
	end

	// combinational reads, used by decode in the fetch cycle
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

/* verilog/core_idu.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_idu (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     ifu_valid_i,
	input  logic [`CORE_XLEN-1:0]    inst_i,
	input  logic [`CORE_XLEN-1:0]    pc_i,
	input  logic [`CORE_XLEN-1:0]    rdata1_i,
	input  logic [`CORE_XLEN-1:0]    rdata2_i,
	output logic [`CORE_RADDR_W-1:0] raddr1_o,
	output logic [`CORE_RADDR_W-1:0] raddr2_o,
	output logic                     valid_o,
	output core_pkg::alu_op_e        alu_op_o,
	output core_pkg::npc_kind_e      npc_kind_o,
	output logic [`CORE_XLEN-1:0]    opa_o,
	output logic [`CORE_XLEN-1:0]    opb_o,
	output logic [`CORE_XLEN-1:0]    cmpb_o,
	output logic [`CORE_XLEN-1:0]    target_o,
	output logic [`CORE_XLEN-1:0]    pc_o,
	output logic                     wen_o,
	output logic [`CORE_RADDR_W-1:0] wreg_o,
	output logic                     ebreak_o,
	output logic                     invalid_o
);
	import core_pkg::*;

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [`CORE_XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
	logic [`CORE_XLEN-1:0] opb, target;
	alu_op_e               alu_op;
	npc_kind_e             npc_kind;
	logic                  wen, ebreak, bad;

	assign opcode   = inst_i[6:0];
	assign funct3   = inst_i[14:12];
	assign funct7   = inst_i[31:25];
	assign raddr1_o = inst_i[19:15];
	assign raddr2_o = inst_i[24:20];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// branch and jump share one adder
	assign target = pc_i + ((opcode == OPC_JAL) ? imm_j : imm_b);

	always_comb begin
		alu_op   = ALU_ADD;
		npc_kind = NPC_SEQ;
		opb      = rdata2_i;
		wen      = 1'b0;
		ebreak   = 1'b0;
		bad      = 1'b0;
		case (opcode)
			OPC_OP: begin
				wen = 1'b1;
				case (funct3)
					F3_ADD_SUB: alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_SLT:     alu_op = ALU_SLT;
					F3_XOR:     alu_op = ALU_XOR;
					F3_OR:      alu_op = ALU_OR;
					F3_AND:     alu_op = ALU_AND;
					default:    bad = 1'b1;
				endcase
				// only SUB may use the alternate funct7
				if (funct7 != F7_BASE && !(funct7 == F7_SUB && funct3 == F3_ADD_SUB))
					bad = 1'b1;
			end
			OPC_OP_IMM: begin
				wen = 1'b1;
				opb = imm_i;
				case (funct3)
					F3_ADD_SUB: alu_op = ALU_ADD;
					F3_XOR:     alu_op = ALU_XOR;
					F3_OR:      alu_op = ALU_OR;
					F3_AND:     alu_op = ALU_AND;
					default:    bad = 1'b1;
				endcase
			end
			OPC_LUI: begin
				wen    = 1'b1;
				opb    = imm_u;
				alu_op = ALU_PASS_B;
			end
			OPC_BRANCH: begin
				case (funct3)
					F3_BEQ:  npc_kind = NPC_BEQ;
					F3_BNE:  npc_kind = NPC_BNE;
					default: bad = 1'b1;
				endcase
			end
			OPC_JAL: begin
				wen      = 1'b1;
				npc_kind = NPC_JUMP;
			end
			OPC_SYSTEM: begin
				if (inst_i == EBREAK_WORD)
					ebreak = 1'b1;
				else
					bad = 1'b1;
			end
			default: bad = 1'b1;
		endcase
		// an invalid word must not write or redirect
		if (bad) begin
			wen      = 1'b0;
			npc_kind = NPC_SEQ;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o    <= 1'b0;
			wen_o      <= 1'b0;
			ebreak_o   <= 1'b0;
			invalid_o  <= 1'b0;
			npc_kind_o <= NPC_SEQ;
		end else begin
			valid_o <= ifu_valid_i;
			if (ifu_valid_i) begin
				wen_o      <= wen;
				ebreak_o   <= ebreak;
				invalid_o  <= bad;
				npc_kind_o <= npc_kind;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ifu_valid_i) begin
			alu_op_o <= alu_op;
			opa_o    <= rdata1_i;
			opb_o    <= opb;
			cmpb_o   <= rdata2_i;
			target_o <= target;
			pc_o     <= pc_i;
			wreg_o   <= inst_i[11:7];
		end
	end

endmodule

/* verilog/core_exu.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_exu (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     idu_valid_i,
	input  core_pkg::alu_op_e        alu_op_i,
	input  core_pkg::npc_kind_e      npc_kind_i,
	input  logic [`CORE_XLEN-1:0]    opa_i,
	input  logic [`CORE_XLEN-1:0]    opb_i,
	input  logic [`CORE_XLEN-1:0]    cmpb_i,
	input  logic [`CORE_XLEN-1:0]    target_i,
	input  logic [`CORE_XLEN-1:0]    pc_i,
	input  logic                     wen_i,
	input  logic [`CORE_RADDR_W-1:0] wreg_i,
	input  logic                     ebreak_i,
	input  logic                     invalid_i,
	output logic                     valid_o,
	output logic                     redirect_o,
	output logic [`CORE_XLEN-1:0]    redirect_pc_o,
	output logic                     wen_o,
	output logic [`CORE_RADDR_W-1:0] wreg_o,
	output logic [`CORE_XLEN-1:0]    result_o,
	output logic                     stop_o,
	output logic                     invalid_o
);
	import core_pkg::*;

	logic [`CORE_XLEN-1:0] alu_res;
	logic [`CORE_XLEN-1:0] result;
	logic                  equal;
	logic                  taken;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:    alu_res = opa_i + opb_i;
			ALU_SUB:    alu_res = opa_i - opb_i;
			ALU_AND:    alu_res = opa_i & opb_i;
			ALU_OR:     alu_res = opa_i | opb_i;
			ALU_XOR:    alu_res = opa_i ^ opb_i;
			ALU_SLT:    alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
			ALU_PASS_B: alu_res = opb_i;
			default:    alu_res = '0;
		endcase
	end

	// JAL writes the link address instead of an ALU value
	assign result = (npc_kind_i == NPC_JUMP) ? pc_i + PC_STEP : alu_res;

	assign equal = (opa_i == cmpb_i);

	always_comb begin
		case (npc_kind_i)
			NPC_BEQ:  taken = equal;
			NPC_BNE:  taken = !equal;
			NPC_JUMP: taken = 1'b1;
			default:  taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o    <= 1'b0;
			redirect_o <= 1'b0;
			wen_o      <= 1'b0;
			stop_o     <= 1'b0;
			invalid_o  <= 1'b0;
		end else begin
			valid_o <= idu_valid_i;
			if (idu_valid_i) begin
				redirect_o <= taken;
				wen_o      <= wen_i;
				stop_o     <= ebreak_i | invalid_i;
				invalid_o  <= invalid_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (idu_valid_i) begin
			redirect_pc_o <= target_i;
			wreg_o        <= wreg_i;
			result_o      <= result;
		end
	end

endmodule

/* verilog/core_wbu.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_wbu (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     exu_valid_i,
	input  logic                     wen_i,
	input  logic [`CORE_RADDR_W-1:0] wreg_i,
	input  logic [`CORE_XLEN-1:0]    result_i,
	input  logic                     stop_i,
	input  logic                     invalid_i,
	output logic                     reg_we_o,
	output logic [`CORE_RADDR_W-1:0] reg_waddr_o,
	output logic [`CORE_XLEN-1:0]    reg_wdata_o,
	output logic                     finish_o,
	output logic                     halt_o,
	output logic                     invalid_o
);
	import core_pkg::*;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			reg_we_o  <= 1'b0;
			finish_o  <= 1'b0;
			halt_o    <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			finish_o <= exu_valid_i;
			// writes to x0 are dropped here, so they never show in the trace
			reg_we_o <= exu_valid_i && wen_i && (wreg_i != REG_X0);
			// sticky until reset
			halt_o    <= halt_o | (exu_valid_i & stop_i);
			invalid_o <= invalid_o | (exu_valid_i & invalid_i);
		end
	end

	always_ff @(posedge clk) begin
		if (exu_valid_i) begin
			reg_waddr_o <= wreg_i;
			reg_wdata_o <= result_i;
		end
	end

endmodule

/* verilog/core_top.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top (
	input  logic                                clk,
	input  logic                                arst_n_i,
	input  logic                                run_i,
	input  logic                                imem_we_i,
	input  logic [$clog2(`CORE_IMEM_DEPTH)-1:0] imem_addr_i,
	input  logic [`CORE_XLEN-1:0]               imem_wdata_i,
	output logic [`CORE_XLEN-1:0]               pc_o,
	output logic                                finish_o,
	output logic                                halt_o,
	output logic                                invalid_o,
	output logic                                trace_we_o,
	output logic [`CORE_RADDR_W-1:0]            trace_waddr_o,
	output logic [`CORE_XLEN-1:0]               trace_wdata_o
);
	import core_pkg::*;

	// fetch to decode
	logic                     ifu_valid;
	logic [`CORE_XLEN-1:0]    ifu_inst;
	// register file read side
	logic [`CORE_RADDR_W-1:0] raddr1, raddr2;
	logic [`CORE_XLEN-1:0]    rdata1, rdata2;
	// decode to execute
	logic                     idu_valid;
	alu_op_e                  idu_alu_op;
	npc_kind_e                idu_npc_kind;
	logic [`CORE_XLEN-1:0]    idu_opa, idu_opb, idu_cmpb, idu_target, idu_pc;
	logic                     idu_wen, idu_ebreak, idu_invalid;
	logic [`CORE_RADDR_W-1:0] idu_wreg;
	// execute to writeback and fetch
	logic                     exu_valid, exu_redirect, exu_wen, exu_stop, exu_invalid;
	logic [`CORE_XLEN-1:0]    exu_redirect_pc, exu_result;
	logic [`CORE_RADDR_W-1:0] exu_wreg;

	core_ifu u_ifu (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.run_i         (run_i),
		.finish_i      (finish_o),
		.halt_i        (halt_o),
		.redirect_i    (exu_redirect),
		.redirect_pc_i (exu_redirect_pc),
		.imem_we_i     (imem_we_i),
		.imem_addr_i   (imem_addr_i),
		.imem_wdata_i  (imem_wdata_i),
		.valid_o       (ifu_valid),
		.inst_o        (ifu_inst),
		.pc_o          (pc_o)
	);

	// the retire trace is the register write port itself
	core_regfile u_regfile (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.we_i     (trace_we_o),
		.waddr_i  (trace_waddr_o),
		.wdata_i  (trace_wdata_o),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	core_idu u_idu (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.ifu_valid_i (ifu_valid),
		.inst_i      (ifu_inst),
		.pc_i        (pc_o),
		.rdata1_i    (rdata1),
		.rdata2_i    (rdata2),
		.raddr1_o    (raddr1),
		.raddr2_o    (raddr2),
		.valid_o     (idu_valid),
		.alu_op_o    (idu_alu_op),
		.npc_kind_o  (idu_npc_kind),
		.opa_o       (idu_opa),
		.opb_o       (idu_opb),
		.cmpb_o      (idu_cmpb),
		.target_o    (idu_target),
		.pc_o        (idu_pc),
		.wen_o       (idu_wen),
		.wreg_o      (idu_wreg),
		.ebreak_o    (idu_ebreak),
		.invalid_o   (idu_invalid)
	);

	core_exu u_exu (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.idu_valid_i   (idu_valid),
		.alu_op_i      (idu_alu_op),
		.npc_kind_i    (idu_npc_kind),
		.opa_i         (idu_opa),
		.opb_i         (idu_opb),
		.cmpb_i        (idu_cmpb),
		.target_i      (idu_target),
		.pc_i          (idu_pc),
		.wen_i         (idu_wen),
		.wreg_i        (idu_wreg),
		.ebreak_i      (idu_ebreak),
		.invalid_i     (idu_invalid),
		.valid_o       (exu_valid),
		.redirect_o    (exu_redirect),
		.redirect_pc_o (exu_redirect_pc),
		.wen_o         (exu_wen),
		.wreg_o        (exu_wreg),
		.result_o      (exu_result),
		.stop_o        (exu_stop),
		.invalid_o     (exu_invalid)
	);

	core_wbu u_wbu (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.exu_valid_i (exu_valid),
		.wen_i       (exu_wen),
		.wreg_i      (exu_wreg),
		.result_i    (exu_result),
		.stop_i      (exu_stop),
		.invalid_i   (exu_invalid),
		.reg_we_o    (trace_we_o),
		.reg_waddr_o (trace_waddr_o),
		.reg_wdata_o (trace_wdata_o),
		.finish_o    (finish_o),
		.halt_o      (halt_o),
		.invalid_o   (invalid_o)
	);

endmodule

/* test/core_assertions.sv */
`timescale 1ns/1ps

module core_assertions (
	input logic clk,
	input logic arst_n_i,
	input logic fetch_i,
	input logic finish_i,
	input logic halt_i,
	input logic invalid_i
);

	// finish lands in the fourth cycle, counting the fetch strobe
	finish_after_fetch: assert property (@(posedge clk) disable iff (!arst_n_i)
		$past(fetch_i, 3) |-> finish_i)
		else $error("finish_o missing three cycles after a fetch strobe");

	finish_needs_fetch: assert property (@(posedge clk) disable iff (!arst_n_i)
		finish_i |-> $past(fetch_i, 3))
		else $error("finish_o without a fetch strobe three cycles before");

	// halt rises with the last finish, nothing retires after that
	quiet_when_halted: assert property (@(posedge clk) disable iff (!arst_n_i)
		halt_i && $past(halt_i) |-> !finish_i)
		else $error("finish_o pulsed while the core was halted");

	invalid_halts: assert property (@(posedge clk) disable iff (!arst_n_i)
		invalid_i |-> halt_i)
		else $error("invalid_o high without halt_o");

endmodule

bind core_top core_assertions u_assertions (
	.clk       (clk),
	.arst_n_i  (arst_n_i),
	.fetch_i   (ifu_valid),
	.finish_i  (finish_o),
	.halt_i    (halt_o),
	.invalid_i (invalid_o)
);

/* test/core_tb.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;
	import core_pkg::*;

	localparam int NUM_TESTS   = 12;
	localparam int MAX_LEN     = 24;
	localparam int IDLE_CYCLES = 10;
	localparam int IMEM_AW     = $clog2(`CORE_IMEM_DEPTH);
	// reset, load, four cycles per instruction and the idle wait, per test
	localparam int CYCLE_LIMIT = NUM_TESTS * (MAX_LEN * 5 + IDLE_CYCLES + 16);

	typedef enum int {
		K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
		K_ADDI, K_ANDI, K_ORI, K_XORI, K_LUI,
		K_BEQ, K_BNE, K_JAL, K_EBREAK, K_BAD
	} kind_e;

	logic               clk;
	logic               arst_n_i;
	logic               run_i;
	logic               imem_we_i;
	logic [IMEM_AW-1:0] imem_addr_i;
	logic [31:0]        imem_wdata_i;
	logic [31:0]        pc_o;
	logic               finish_o;
	logic               halt_o;
	logic               invalid_o;
	logic               trace_we_o;
	logic [4:0]         trace_waddr_o;
	logic [31:0]        trace_wdata_o;

	// program under test, fields kept next to the encoded word
	kind_e       p_kind [MAX_LEN];
	logic [4:0]  p_rd   [MAX_LEN];
	logic [4:0]  p_rs1  [MAX_LEN];
	logic [4:0]  p_rs2  [MAX_LEN];
	logic [31:0] p_imm  [MAX_LEN];
	logic [31:0] p_word [MAX_LEN];
	int          plen;

	// expected retire sequence from the model
	logic [31:0] exp_pc    [$];
	logic [4:0]  exp_waddr [$];
	logic [31:0] exp_wdata [$];
	logic        exp_invalid;

	int seed         = 5235;
	int cycles       = 0;
	int errors       = 0;
	int checks       = 0;
	int failed_tests = 0;

	core_top dut (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.run_i         (run_i),
		.imem_we_i     (imem_we_i),
		.imem_addr_i   (imem_addr_i),
		.imem_wdata_i  (imem_wdata_i),
		.pc_o          (pc_o),
		.finish_o      (finish_o),
		.halt_o        (halt_o),
		.invalid_o     (invalid_o),
		.trace_we_o    (trace_we_o),
		.trace_waddr_o (trace_waddr_o),
		.trace_wdata_o (trace_wdata_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %0t: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// few registers, so operands collide and branches go both ways
	function automatic logic [4:0] rand_reg();
		return 5'(rand_below(8));
	endfunction

	task automatic add_inst(input kind_e k, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [31:0] imm);
		logic [31:0] w;
		case (k)
			K_ADD:    w = {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
			K_SUB:    w = {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
			K_AND:    w = {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
			K_OR:     w = {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
			K_XOR:    w = {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
			K_SLT:    w = {7'b0000000, rs2, rs1, 3'b010, rd, OPC_OP};
			K_ADDI:   w = {imm[11:0], rs1, 3'b000, rd, OPC_OP_IMM};
			K_ANDI:   w = {imm[11:0], rs1, 3'b111, rd, OPC_OP_IMM};
			K_ORI:    w = {imm[11:0], rs1, 3'b110, rd, OPC_OP_IMM};
			K_XORI:   w = {imm[11:0], rs1, 3'b100, rd, OPC_OP_IMM};
			K_LUI:    w = {imm[31:12], rd, OPC_LUI};
			K_BEQ:    w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
			K_BNE:    w = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
			K_JAL:    w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
			K_EBREAK: w = 32'h0010_0073;
			// load, store, auipc or jalr opcode with random upper bits
			default:  w = {imm[31:7], imm[1] ? (imm[0] ? 7'b1100111 : 7'b0010111)
				: (imm[0] ? 7'b0100011 : 7'b0000011)};
		endcase
		p_kind[plen] = k;
		p_rd[plen]   = rd;
		p_rs1[plen]  = rs1;
		p_rs2[plen]  = rs2;
		p_imm[plen]  = imm;
		p_word[plen] = w;
		plen++;
	endtask

	// mode 0 ALU only, mode 1 with branches and jumps, mode 2 with one bad word
	task automatic gen_program(input int mode);
		int          body;
		int          bad_at;
		int          choices;
		kind_e       k;
		logic [31:0] r;
		logic [31:0] imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		plen    = 0;
		body    = 8 + rand_below(MAX_LEN - 8);
		bad_at  = rand_below(body);
		choices = (mode == 1) ? 14 : 11;
		for (int i = 0; i < body; i++) begin
			k   = kind_e'(rand_below(choices));
			r   = $random(seed);
			imm = {{20{r[11]}}, r[11:0]};
			if (mode == 2 && i == bad_at) begin
				k   = K_BAD;
				imm = r;
			end else if (k == K_LUI) begin
				imm = {r[31:12], 12'b0};
			end else if (k == K_BEQ || k == K_BNE || k == K_JAL) begin
				// forward only, at most up to the closing ebreak
				imm = 32'((1 + rand_below(body - i)) * 4);
			end
			rd  = rand_reg();
			rs1 = rand_reg();
			rs2 = rand_reg();
			add_inst(k, rd, rs1, rs2, imm);
		end
		add_inst(K_EBREAK, '0, '0, '0, '0);
	endtask

	// writes x0, then uses it as an operand
	task automatic x0_program();
		plen = 0;
		add_inst(K_ADDI, 5'd0, 5'd0, 5'd0, 32'd123);
		add_inst(K_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
		add_inst(K_LUI, 5'd0, 5'd0, 5'd0, 32'h1234_5000);
		add_inst(K_ADD, 5'd2, 5'd0, 5'd1, '0);
		add_inst(K_SUB, 5'd3, 5'd1, 5'd0, '0);
		add_inst(K_ORI, 5'd4, 5'd0, 5'd0, 32'hffff_ffff);
		add_inst(K_BEQ, 5'd0, 5'd0, 5'd5, 32'd8);
		add_inst(K_ADDI, 5'd6, 5'd0, 5'd0, 32'd7);
		add_inst(K_SLT, 5'd7, 5'd0, 5'd4, '0);
		add_inst(K_EBREAK, '0, '0, '0, '0);
	endtask

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		int          idx;
		bit          done;
		bit          wr;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc          = '0;
		done        = 1'b0;
		exp_invalid = 1'b0;
		exp_pc.delete();
		exp_waddr.delete();
		exp_wdata.delete();
		while (!done) begin
			idx = int'(pc >> 2);
			a   = regs[p_rs1[idx]];
			b   = regs[p_rs2[idx]];
			wr  = 1'b1;
			val = '0;
			exp_pc.push_back(pc);
			pc = pc + 4;
			case (p_kind[idx])
				K_ADD:  val = a + b;
				K_SUB:  val = a - b;
				K_AND:  val = a & b;
				K_OR:   val = a | b;
				K_XOR:  val = a ^ b;
				K_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				K_ADDI: val = a + p_imm[idx];
				K_ANDI: val = a & p_imm[idx];
				K_ORI:  val = a | p_imm[idx];
				K_XORI: val = a ^ p_imm[idx];
				K_LUI:  val = p_imm[idx];
				K_BEQ, K_BNE: begin
					wr = 1'b0;
					if ((a == b) == (p_kind[idx] == K_BEQ))
						pc = exp_pc[$] + p_imm[idx];
				end
				K_JAL: begin
					val = pc;
					pc  = exp_pc[$] + p_imm[idx];
				end
				K_BAD: begin
					wr          = 1'b0;
					done        = 1'b1;
					exp_invalid = 1'b1;
				end
				// ebreak
				default: begin
					wr   = 1'b0;
					done = 1'b1;
				end
			endcase
			if (wr && p_rd[idx] != '0) begin
				regs[p_rd[idx]] = val;
				exp_waddr.push_back(p_rd[idx]);
				exp_wdata.push_back(val);
			end
		end
	endtask

	// retire monitor, pc_o still holds the retiring pc in the finish cycle
	always @(negedge clk) begin
		if (arst_n_i && finish_o) begin
			if (exp_pc.size() == 0) begin
				errors++;
				$display("finish pulse at %0t with no instruction left to retire", $time);
			end else begin
				check("pc_o", exp_pc.pop_front(), pc_o);
			end
		end
		if (arst_n_i && trace_we_o) begin
			if (exp_waddr.size() == 0) begin
				errors++;
				$display("register write to x%0d at %0t was not expected", trace_waddr_o, $time);
			end else begin
				check("trace_waddr_o", 32'(exp_waddr.pop_front()), 32'(trace_waddr_o));
				check("trace_wdata_o", exp_wdata.pop_front(), trace_wdata_o);
			end
		end
	end

	task automatic reset_core();
		@(posedge clk);
		arst_n_i  <= 1'b0;
		run_i     <= 1'b0;
		imem_we_i <= 1'b0;
		repeat (2) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		check("finish_o", 32'd0, 32'(finish_o));
		check("halt_o", 32'd0, 32'(halt_o));
		check("invalid_o", 32'd0, 32'(invalid_o));
		check("pc_o", 32'd0, pc_o);
	endtask

	task automatic load_program();
		for (int i = 0; i < plen; i++) begin
			@(posedge clk);
			imem_we_i    <= 1'b1;
			imem_addr_i  <= IMEM_AW'(i);
			imem_wdata_i <= p_word[i];
		end
		@(posedge clk);
		imem_we_i <= 1'b0;
	endtask

	task automatic run_test(input int t, input int mode);
		int errs_before;
		errs_before = errors;
		reset_core();
		if (mode == 3)
			x0_program();
		else
			gen_program(mode);
		load_program();
		run_model();
		@(posedge clk);
		run_i <= 1'b1;
		while (!halt_o)
			@(negedge clk);
		// extra finish pulses or writes here are caught by the monitor
		repeat (IDLE_CYCLES) @(negedge clk);
		check("halt_o", 32'd1, 32'(halt_o));
		check("invalid_o", 32'(exp_invalid), 32'(invalid_o));
		if (exp_pc.size() != 0 || exp_waddr.size() != 0) begin
			errors++;
			$display("test %0d: %0d retires and %0d register writes never appeared",
				t, exp_pc.size(), exp_waddr.size());
		end
		@(posedge clk);
		run_i <= 1'b0;
		if (errors != errs_before)
			failed_tests++;
		$display("test %0d mode %0d: %0d words, %s", t, mode, plen,
			(errors == errs_before) ? "ok" : "FAILED");
	endtask

	initial begin
		arst_n_i     = 1'b0;
		run_i        = 1'b0;
		imem_we_i    = 1'b0;
		imem_addr_i  = '0;
		imem_wdata_i = '0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t, (t == 3) ? 3 : t % 3);
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			NUM_TESTS, failed_tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* core.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/core_ifu.sv
verilog/core_regfile.sv
verilog/core_idu.sv
verilog/core_exu.sv
verilog/core_wbu.sv
verilog/core_top.sv
test/core_assertions.sv
test/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f core.f --top-module core_tb -Mdir "$OBJ" -o core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
exit 0
